/* axi_trace_macros.svh */
// *********************************************************************
// AXI trace unit shared sizes
// Widths, trace buffer depth and APB register offsets used by the
// package, the RTL and the testbench
// *********************************************************************

`ifndef AXI_TRACE_MACROS_SVH
`define AXI_TRACE_MACROS_SVH

`define AXI_TRACE_ID_W   4
`define AXI_TRACE_TS_W   16
`define AXI_TRACE_DEPTH  8

// Width of the buffer occupancy count, which must reach DEPTH itself
`define AXI_TRACE_CNT_W  ($clog2(`AXI_TRACE_DEPTH + 1))

`define AXI_TRACE_REG_CTRL    8'h00
`define AXI_TRACE_REG_STATUS  8'h04
`define AXI_TRACE_REG_HDR     8'h08
`define AXI_TRACE_REG_W0      8'h0C
`define AXI_TRACE_REG_W1      8'h10

`endif

/* axi_trace_pkg.sv */
// *********************************************************************
// AXI trace unit types
// AXI tap and APB structs, channel code and the trace record with its
// two payload views
// *********************************************************************

`include "axi_trace_macros.svh"

package axi_trace_pkg;

  typedef enum logic [2:0] {
    NONE = 3'd0,
    AW   = 3'd1,
    AR   = 3'd2,
    W    = 3'd3,
    B    = 3'd4,
    R    = 3'd5
  } trace_chan_e;

  typedef logic [`AXI_TRACE_ID_W-1:0] axi_id_t;

  // AW and AR carry the same fields
  typedef struct packed {
    axi_id_t     id;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } axi_ax_t;

  typedef axi_ax_t axi_aw_t;
  typedef axi_ax_t axi_ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t    id;
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t     id;
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } axi_r_t;

  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_ar_t ar;
    logic    ar_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    axi_b_t b;
    logic   b_valid;
    axi_r_t r;
    logic   r_valid;
    logic   aw_ready;
    logic   ar_ready;
    logic   w_ready;
  } axi_rsp_t;

  // Both payload views are 45 bits wide
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } trace_addr_view_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  resp;
    logic        last;
    logic [5:0]  pad;
  } trace_data_view_t;

  typedef union packed {
    trace_addr_view_t addr_view;
    trace_data_view_t data_view;
  } trace_payload_u;

  typedef struct packed {
    trace_chan_e                chan;
    axi_id_t                    id;
    logic [`AXI_TRACE_TS_W-1:0] ts;
    trace_payload_u             payload;
  } trace_rec_t;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

/* axi_beat_capture.sv */
// *********************************************************************
// AXI beat capture
// Detects handshakes on the five AXI channels, filters them by mask
// and enable, and registers a timestamped trace record per beat
// *********************************************************************

`timescale 1ns/1ps

`include "axi_trace_macros.svh"

module axi_beat_capture (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  axi_trace_pkg::axi_req_t         axi_req_i,
  input  axi_trace_pkg::axi_rsp_t         axi_rsp_i,
  input  logic [4:0]                      chan_mask_i,
  input  logic                            capture_en_i,
  output axi_trace_pkg::trace_rec_t [4:0] beat_rec_o,
  output logic [4:0]                      beat_valid_o
);

  import axi_trace_pkg::*;

  logic [`AXI_TRACE_TS_W-1:0] ts_q;
  logic [4:0]                 hs_raw;
  logic [4:0]                 hs;
  trace_rec_t [4:0]           rec_d;

  function automatic trace_rec_t addr_rec(trace_chan_e chan, axi_ax_t ax,
                                          logic [`AXI_TRACE_TS_W-1:0] ts);
    trace_rec_t rec;
    rec                           = '0;
    rec.chan                      = chan;
    rec.id                        = ax.id;
    rec.ts                        = ts;
    rec.payload.addr_view.addr    = ax.addr;
    rec.payload.addr_view.len     = ax.len;
    rec.payload.addr_view.size    = ax.size;
    rec.payload.addr_view.burst   = ax.burst;
    return rec;
  endfunction

  // Bits follow the CTRL mask order with AW at bit 0 and R at bit 4
  assign hs_raw[0] = axi_req_i.aw_valid & axi_rsp_i.aw_ready;
  assign hs_raw[1] = axi_req_i.ar_valid & axi_rsp_i.ar_ready;
  assign hs_raw[2] = axi_req_i.w_valid  & axi_rsp_i.w_ready;
  assign hs_raw[3] = axi_rsp_i.b_valid  & axi_req_i.b_ready;
  assign hs_raw[4] = axi_rsp_i.r_valid  & axi_req_i.r_ready;

  assign hs = hs_raw & chan_mask_i & {5{capture_en_i}};

  always_comb begin
    rec_d[0] = addr_rec(AW, axi_req_i.aw, ts_q);
    rec_d[1] = addr_rec(AR, axi_req_i.ar, ts_q);

    // W carries no ID on AXI4, so the record ID stays 0
    rec_d[2]                        = '0;
    rec_d[2].chan                   = W;
    rec_d[2].ts                     = ts_q;
    rec_d[2].payload.data_view.data = axi_req_i.w.data;
    rec_d[2].payload.data_view.strb = axi_req_i.w.strb;
    rec_d[2].payload.data_view.last = axi_req_i.w.last;

    rec_d[3]                        = '0;
    rec_d[3].chan                   = B;
    rec_d[3].id                     = axi_rsp_i.b.id;
    rec_d[3].ts                     = ts_q;
    rec_d[3].payload.data_view.resp = axi_rsp_i.b.resp;

    rec_d[4]                        = '0;
    rec_d[4].chan                   = R;
    rec_d[4].id                     = axi_rsp_i.r.id;
    rec_d[4].ts                     = ts_q;
    rec_d[4].payload.data_view.data = axi_rsp_i.r.data;
    rec_d[4].payload.data_view.resp = axi_rsp_i.r.resp;
    rec_d[4].payload.data_view.last = axi_rsp_i.r.last;
  end

  // The free-running cycle counter wraps silently
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      ts_q         <= '0;
      beat_valid_o <= '0;
    end else begin
      ts_q         <= ts_q + 1'b1;
      beat_valid_o <= hs;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 5; i++) begin
      if (hs[i]) begin
        beat_rec_o[i] <= rec_d[i];
      end
    end
  end

endmodule

/* trace_serializer.sv */
// *********************************************************************
// Trace serializer
// Holds one pending record per channel and forwards one record per
// cycle to the trace buffer in fixed priority AW, AR, W, B, R
// *********************************************************************

`timescale 1ns/1ps

module trace_serializer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  axi_trace_pkg::trace_rec_t [4:0] beat_rec_i,
  input  logic [4:0]                      beat_valid_i,
  input  logic                            fifo_full_i,
  output logic                            push_o,
  output axi_trace_pkg::trace_rec_t       push_rec_o,
  output logic [2:0]                      drop_o
);

  import axi_trace_pkg::*;

  trace_rec_t [4:0] slot_q;
  logic [4:0]       slot_vld_q;
  logic [4:0]       take;
  logic [4:0]       load;
  logic [4:0]       busy_drop;
  logic             any_vld;

  // Lowest occupied index wins, so scan downwards and keep the last hit
  always_comb begin
    take       = '0;
    push_rec_o = slot_q[0];
    for (int i = 4; i >= 0; i--) begin
      if (slot_vld_q[i]) begin
        take       = '0;
        take[i]    = 1'b1;
        push_rec_o = slot_q[i];
      end
    end
  end

  assign any_vld = |slot_vld_q;

  // The selected slot always leaves; with the buffer full it is lost
  assign push_o = any_vld & ~fifo_full_i;

  // A slot that empties this cycle can take a new beat at once
  assign load      = beat_valid_i & (~slot_vld_q | take);
  assign busy_drop = beat_valid_i & slot_vld_q & ~take;

  always_comb begin
    drop_o = {2'b00, any_vld & fifo_full_i};
    for (int i = 0; i < 5; i++) begin
      drop_o = drop_o + {2'b00, busy_drop[i]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      slot_vld_q <= '0;
    end else begin
      slot_vld_q <= (slot_vld_q & ~take) | load;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 5; i++) begin
      if (load[i]) begin
        slot_q[i] <= beat_rec_i[i];
      end
    end
  end

endmodule

/* trace_fifo.sv */
// *********************************************************************
// Trace buffer
// Circular buffer of trace records with occupancy count and flags
// *********************************************************************

`timescale 1ns/1ps

`include "axi_trace_macros.svh"

module trace_fifo #(
  parameter int unsigned DEPTH = `AXI_TRACE_DEPTH
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push_i,
  input  axi_trace_pkg::trace_rec_t    push_rec_i,
  input  logic                         pop_i,
  output axi_trace_pkg::trace_rec_t    head_rec_o,
  output logic                         empty_o,
  output logic                         full_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  import axi_trace_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  trace_rec_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o    = (count_o == '0);
  assign full_o     = (count_o == CNT_W'(DEPTH));
  assign head_rec_o = mem_q[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Pointers wrap naturally since DEPTH is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_rec_i;
    end
  end

endmodule

/* trace_apb_regs.sv */
// *********************************************************************
// Trace APB register block
// Zero wait state APB slave holding capture control and the drop
// counter, and presenting the buffer head record for read-out
// *********************************************************************

`timescale 1ns/1ps

`include "axi_trace_macros.svh"

module trace_apb_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  axi_trace_pkg::apb_req_t      apb_req_i,
  output axi_trace_pkg::apb_rsp_t      apb_rsp_o,
  input  axi_trace_pkg::trace_rec_t    head_rec_i,
  input  logic                         empty_i,
  input  logic [`AXI_TRACE_CNT_W-1:0]  count_i,
  input  logic [2:0]                   drop_i,
  output logic                         pop_o,
  output logic [4:0]                   chan_mask_o,
  output logic                         capture_en_o
);

  import axi_trace_pkg::*;

  logic        access;
  logic        addr_ok;
  logic        ctrl_wr;
  logic        status_wr;
  logic [7:0]  drop_cnt_q;
  logic [8:0]  drop_sum;
  logic        is_addr_rec;
  logic [31:0] rec_hdr;
  logic [31:0] rec_w0;
  logic [31:0] rec_w1;

  assign access = apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    case (apb_req_i.paddr)
      `AXI_TRACE_REG_CTRL,
      `AXI_TRACE_REG_STATUS,
      `AXI_TRACE_REG_HDR,
      `AXI_TRACE_REG_W0,
      `AXI_TRACE_REG_W1: addr_ok = 1'b1;
      default:           addr_ok = 1'b0;
    endcase
  end

  assign ctrl_wr   = access & apb_req_i.pwrite & (apb_req_i.paddr == `AXI_TRACE_REG_CTRL);
  assign status_wr = access & apb_req_i.pwrite & (apb_req_i.paddr == `AXI_TRACE_REG_STATUS);

  // Reading the last record word consumes the head
  assign pop_o = access & ~apb_req_i.pwrite & ~empty_i &
                 (apb_req_i.paddr == `AXI_TRACE_REG_W1);

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      chan_mask_o  <= '0;
      capture_en_o <= 1'b0;
    end else if (ctrl_wr) begin
      chan_mask_o  <= apb_req_i.pwdata[4:0];
      capture_en_o <= apb_req_i.pwdata[8];
    end
  end

  // Saturating drop counter; a STATUS write clears it
  assign drop_sum = {1'b0, drop_cnt_q} + {6'b0, drop_i};

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      drop_cnt_q <= '0;
    end else if (status_wr) begin
      drop_cnt_q <= '0;
    end else if (drop_sum[8]) begin
      drop_cnt_q <= 8'hFF;
    end else begin
      drop_cnt_q <= drop_sum[7:0];
    end
  end

  // Split the head record into the three read words
  always_comb begin
    is_addr_rec = (head_rec_i.chan == AW) || (head_rec_i.chan == AR);
    rec_hdr     = '0;
    rec_w0      = '0;
    rec_w1      = '0;
    if (!empty_i) begin
      rec_hdr[2:0]   = head_rec_i.chan;
      rec_hdr[7:4]   = head_rec_i.id;
      rec_hdr[31:16] = head_rec_i.ts;
      if (is_addr_rec) begin
        rec_w0         = head_rec_i.payload.addr_view.addr;
        rec_w1[7:0]    = head_rec_i.payload.addr_view.len;
        rec_w1[10:8]   = head_rec_i.payload.addr_view.size;
        rec_w1[13:12]  = head_rec_i.payload.addr_view.burst;
      end else begin
        rec_w0         = head_rec_i.payload.data_view.data;
        rec_w1[3:0]    = head_rec_i.payload.data_view.strb;
        rec_w1[5:4]    = head_rec_i.payload.data_view.resp;
        rec_w1[8]      = head_rec_i.payload.data_view.last;
      end
    end
  end

  always_comb begin
    case (apb_req_i.paddr)
      `AXI_TRACE_REG_CTRL:   apb_rsp_o.prdata = {23'b0, capture_en_o, 3'b0, chan_mask_o};
      `AXI_TRACE_REG_STATUS: apb_rsp_o.prdata = {8'h00, drop_cnt_q, 8'h00, 8'(count_i)};
      `AXI_TRACE_REG_HDR:    apb_rsp_o.prdata = rec_hdr;
      `AXI_TRACE_REG_W0:     apb_rsp_o.prdata = rec_w0;
      `AXI_TRACE_REG_W1:     apb_rsp_o.prdata = rec_w1;
      default:               apb_rsp_o.prdata = '0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & ~addr_ok;

endmodule

/* axi_trace_top.sv */
// *********************************************************************
// AXI trace unit
// Passive AXI4 tap feeding capture, serializer and trace buffer, with
// APB access to control, status and the recorded beats
// *********************************************************************

`timescale 1ns/1ps

`include "axi_trace_macros.svh"

module axi_trace_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  axi_trace_pkg::axi_req_t axi_req_i,
  input  axi_trace_pkg::axi_rsp_t axi_rsp_i,
  input  axi_trace_pkg::apb_req_t apb_req_i,
  output axi_trace_pkg::apb_rsp_t apb_rsp_o
);

  import axi_trace_pkg::*;

  trace_rec_t [4:0]            beat_rec;
  logic [4:0]                  beat_valid;
  logic [4:0]                  chan_mask;
  logic                        capture_en;
  logic                        push;
  trace_rec_t                  push_rec;
  logic [2:0]                  drop;
  trace_rec_t                  head_rec;
  logic                        fifo_empty;
  logic                        fifo_full;
  logic [`AXI_TRACE_CNT_W-1:0] count;
  logic                        pop;

  axi_beat_capture i_axi_beat_capture (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .axi_req_i    ( axi_req_i  ),
    .axi_rsp_i    ( axi_rsp_i  ),
    .chan_mask_i  ( chan_mask  ),
    .capture_en_i ( capture_en ),
    .beat_rec_o   ( beat_rec   ),
    .beat_valid_o ( beat_valid )
  );

  trace_serializer i_trace_serializer (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .beat_rec_i   ( beat_rec   ),
    .beat_valid_i ( beat_valid ),
    .fifo_full_i  ( fifo_full  ),
    .push_o       ( push       ),
    .push_rec_o   ( push_rec   ),
    .drop_o       ( drop       )
  );

  trace_fifo #(
    .DEPTH ( `AXI_TRACE_DEPTH )
  ) i_trace_fifo (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .push_i     ( push       ),
    .push_rec_i ( push_rec   ),
    .pop_i      ( pop        ),
    .head_rec_o ( head_rec   ),
    .empty_o    ( fifo_empty ),
    .full_o     ( fifo_full  ),
    .count_o    ( count      )
  );

  trace_apb_regs i_trace_apb_regs (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .apb_req_i    ( apb_req_i  ),
    .apb_rsp_o    ( apb_rsp_o  ),
    .head_rec_i   ( head_rec   ),
    .empty_i      ( fifo_empty ),
    .count_i      ( count      ),
    .drop_i       ( drop       ),
    .pop_o        ( pop        ),
    .chan_mask_o  ( chan_mask  ),
    .capture_en_o ( capture_en )
  );

endmodule

/* axi_trace_properties.sv */
// *********************************************************************
// AXI trace unit properties
// Concurrent checks on the APB response and the trace buffer handshakes
// *********************************************************************

`timescale 1ns/1ps

`include "axi_trace_macros.svh"

module axi_trace_properties (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        pready_i,
  input logic                        push_i,
  input logic                        full_i,
  input logic                        pop_i,
  input logic                        empty_i,
  input logic [`AXI_TRACE_CNT_W-1:0] count_i
);

  // The APB slave never inserts wait states
  pready_high: assert property (@(posedge clk_i) disable iff (rst_ni) pready_i)
    else $error("APB pready dropped low");

  push_not_full: assert property (@(posedge clk_i) disable iff (rst_ni) push_i |-> !full_i)
    else $error("Trace buffer pushed while full");

  pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_ni) pop_i |-> !empty_i)
    else $error("Trace buffer popped while empty");

  count_in_range: assert property (@(posedge clk_i) disable iff (rst_ni)
                                   count_i <= `AXI_TRACE_DEPTH)
    else $error("Trace buffer count exceeds its depth");

endmodule

bind axi_trace_top axi_trace_properties u_axi_trace_properties (
  .clk_i    ( clk_i            ),
  .rst_ni   ( rst_ni           ),
  .pready_i ( apb_rsp_o.pready ),
  .push_i   ( push             ),
  .full_i   ( fifo_full        ),
  .pop_i    ( pop              ),
  .empty_i  ( fifo_empty       ),
  .count_i  ( count            )
);

/* tb_axi_trace.sv */
// *********************************************************************
// AXI trace unit testbench
// Directed tests that drive the AXI tap and read the trace records,
// control and status back over APB
// *********************************************************************

`timescale 1ns/1ps

`include "axi_trace_macros.svh"

module tb_axi_trace;

  import axi_trace_pkg::*;

  // About eight times the length of the whole test sequence
  localparam int unsigned TIMEOUT_CYCLES = 3000;
  localparam int unsigned DEPTH          = `AXI_TRACE_DEPTH;

  logic        clk_i;
  logic        rst_ni;
  axi_req_t    axi_req;
  axi_rsp_t    axi_rsp;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        apb_err;
  int unsigned cycle_cnt = 0;
  int unsigned err_cnt = 0;

  // Payloads presented on the next beat
  axi_ax_t aw_stim;
  axi_ax_t ar_stim;
  axi_w_t  w_stim;
  axi_b_t  b_stim;
  axi_r_t  r_stim;

  axi_trace_top DUT (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .axi_req_i ( axi_req ),
    .axi_rsp_i ( axi_rsp ),
    .apb_req_i ( apb_req ),
    .apb_rsp_o ( apb_rsp )
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("[FAIL] time %0d ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at the first mismatch");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
      else report_mismatch($sformatf("%s: got 0x%08h, expected 0x%08h", what, got, exp));
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    apb_req.pwrite  <= 1'b1;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    apb_err = apb_rsp.pslverr;
    @(posedge clk_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  // Read data is taken mid-cycle, before the access takes effect
  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    apb_req.paddr   <= addr;
    apb_req.pwrite  <= 1'b0;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    data    = apb_rsp.prdata;
    apb_err = apb_rsp.pslverr;
    @(posedge clk_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  // Bit order of both vectors is AW, AR, W, B, R
  task automatic axi_beat(input logic [4:0] valid, input logic [4:0] ready);
    @(posedge clk_i);
    axi_req.aw       <= aw_stim;
    axi_req.ar       <= ar_stim;
    axi_req.w        <= w_stim;
    axi_rsp.b        <= b_stim;
    axi_rsp.r        <= r_stim;
    axi_req.aw_valid <= valid[0];
    axi_rsp.aw_ready <= ready[0];
    axi_req.ar_valid <= valid[1];
    axi_rsp.ar_ready <= ready[1];
    axi_req.w_valid  <= valid[2];
    axi_rsp.w_ready  <= ready[2];
    axi_rsp.b_valid  <= valid[3];
    axi_req.b_ready  <= ready[3];
    axi_rsp.r_valid  <= valid[4];
    axi_req.r_ready  <= ready[4];
    @(posedge clk_i);
    axi_req.aw_valid <= 1'b0;
    axi_rsp.aw_ready <= 1'b0;
    axi_req.ar_valid <= 1'b0;
    axi_rsp.ar_ready <= 1'b0;
    axi_req.w_valid  <= 1'b0;
    axi_rsp.w_ready  <= 1'b0;
    axi_rsp.b_valid  <= 1'b0;
    axi_req.b_ready  <= 1'b0;
    axi_rsp.r_valid  <= 1'b0;
    axi_req.r_ready  <= 1'b0;
  endtask

  function automatic axi_ax_t rand_ax();
    axi_ax_t ax;
    ax.id    = axi_id_t'($urandom);
    ax.addr  = $urandom;
    ax.len   = 8'($urandom);
    ax.size  = 3'($urandom);
    ax.burst = 2'($urandom);
    return ax;
  endfunction

  task automatic draw_stimulus();
    aw_stim = rand_ax();
    ar_stim = rand_ax();
    w_stim  = '{data: $urandom, strb: 4'($urandom), last: 1'($urandom)};
    b_stim  = '{id: axi_id_t'($urandom), resp: 2'($urandom)};
    r_stim  = '{id: axi_id_t'($urandom), data: $urandom, resp: 2'($urandom),
                last: 1'($urandom)};
  endtask

  // Polls the STATUS buffer count until it holds the expected value
  task automatic poll_count(input int unsigned n);
    logic [31:0] status;
    apb_read(`AXI_TRACE_REG_STATUS, status);
    while (status[7:0] != 8'(n)) begin
      apb_read(`AXI_TRACE_REG_STATUS, status);
    end
  endtask

  task automatic read_record(output logic [31:0] hdr, output logic [31:0] w0,
                             output logic [31:0] w1);
    apb_read(`AXI_TRACE_REG_HDR, hdr);
    apb_read(`AXI_TRACE_REG_W0, w0);
    apb_read(`AXI_TRACE_REG_W1, w1);
  endtask

  task automatic expect_addr_rec(input trace_chan_e chan, input axi_ax_t ax,
                                 output logic [15:0] ts);
    logic [31:0] hdr;
    logic [31:0] w0;
    logic [31:0] w1;
    read_record(hdr, w0, w1);
    check_eq(32'(hdr[2:0]), 32'(chan), "record channel");
    check_eq(32'(hdr[7:4]), 32'(ax.id), "record id");
    check_eq(w0, ax.addr, "record address");
    check_eq(w1, {18'b0, ax.burst, 1'b0, ax.size, ax.len}, "record len, size and burst");
    ts = hdr[31:16];
  endtask

  task automatic expect_data_rec(input trace_chan_e chan, input axi_id_t id,
                                 input logic [31:0] data, input logic [3:0] strb,
                                 input logic [1:0] resp, input logic last,
                                 output logic [15:0] ts);
    logic [31:0] hdr;
    logic [31:0] w0;
    logic [31:0] w1;
    read_record(hdr, w0, w1);
    check_eq(32'(hdr[2:0]), 32'(chan), "record channel");
    check_eq(32'(hdr[7:4]), 32'(id), "record id");
    check_eq(w0, data, "record data");
    check_eq(w1, {23'b0, last, 2'b0, resp, strb}, "record strb, resp and last");
    ts = hdr[31:16];
  endtask

  task automatic reset_state_test();
    logic [31:0] rdata;
    apb_read(`AXI_TRACE_REG_CTRL, rdata);
    check_eq(rdata, 32'h0, "CTRL after reset");
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(rdata, 32'h0, "STATUS after reset");
    // Capture is off, so these handshakes must leave no trace
    draw_stimulus();
    axi_beat(5'h1F, 5'h1F);
    repeat (8) @(posedge clk_i);
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(rdata, 32'h0, "STATUS with capture disabled");
    apb_read(`AXI_TRACE_REG_HDR, rdata);
    check_eq(rdata, 32'h0, "REC_HDR with capture disabled");
  endtask

  task automatic addr_record_test();
    logic [15:0] ts;
    logic [31:0] rdata;
    apb_write(`AXI_TRACE_REG_CTRL, 32'h0000_0103);
    draw_stimulus();
    axi_beat(5'b00001, 5'b00001);
    poll_count(1);
    expect_addr_rec(AW, aw_stim, ts);
    draw_stimulus();
    axi_beat(5'b00010, 5'b00010);
    poll_count(1);
    expect_addr_rec(AR, ar_stim, ts);
    // Valid held without ready is no handshake
    axi_beat(5'b00011, 5'b00000);
    repeat (8) @(posedge clk_i);
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(32'(rdata[7:0]), 32'h0, "count after valid without ready");
  endtask

  task automatic data_order_test();
    logic [15:0] ts_first;
    logic [15:0] ts;
    apb_write(`AXI_TRACE_REG_CTRL, 32'h0000_011F);
    draw_stimulus();
    axi_beat(5'h1F, 5'h1F);
    poll_count(5);
    expect_addr_rec(AW, aw_stim, ts_first);
    expect_addr_rec(AR, ar_stim, ts);
    check_eq(32'(ts), 32'(ts_first), "AR timestamp");
    // W has no ID on AXI4
    expect_data_rec(W, '0, w_stim.data, w_stim.strb, 2'b00, w_stim.last, ts);
    check_eq(32'(ts), 32'(ts_first), "W timestamp");
    expect_data_rec(B, b_stim.id, 32'h0, 4'h0, b_stim.resp, 1'b0, ts);
    check_eq(32'(ts), 32'(ts_first), "B timestamp");
    expect_data_rec(R, r_stim.id, r_stim.data, 4'h0, r_stim.resp, r_stim.last, ts);
    check_eq(32'(ts), 32'(ts_first), "R timestamp");
    draw_stimulus();
    axi_beat(5'b00001, 5'b00001);
    poll_count(1);
    expect_addr_rec(AW, aw_stim, ts);
    assert (ts > ts_first)
      else report_mismatch("a later beat does not carry a larger timestamp");
  endtask

  task automatic mask_filter_test();
    logic [15:0] ts;
    logic [31:0] rdata;
    apb_write(`AXI_TRACE_REG_CTRL, 32'h0000_010B);
    draw_stimulus();
    axi_beat(5'h1F, 5'h1F);
    poll_count(3);
    repeat (8) @(posedge clk_i);
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(32'(rdata[7:0]), 32'd3, "count with W and R masked");
    expect_addr_rec(AW, aw_stim, ts);
    expect_addr_rec(AR, ar_stim, ts);
    expect_data_rec(B, b_stim.id, 32'h0, 4'h0, b_stim.resp, 1'b0, ts);
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(32'(rdata[7:0]), 32'h0, "count after draining masked beats");
  endtask

  // Each beat is fully settled within the six cycles before the next one
  task automatic overflow_test();
    axi_ax_t     sent_q[$];
    logic [15:0] ts;
    logic [31:0] rdata;
    apb_write(`AXI_TRACE_REG_CTRL, 32'h0000_0101);
    apb_write(`AXI_TRACE_REG_STATUS, 32'h0);
    for (int i = 0; i < DEPTH + 3; i++) begin
      draw_stimulus();
      sent_q.push_back(aw_stim);
      axi_beat(5'b00001, 5'b00001);
      repeat (4) @(posedge clk_i);
    end
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(32'(rdata[7:0]), DEPTH, "count when the buffer overflowed");
    check_eq(32'(rdata[23:16]), 32'd3, "drop count after overflow");
    for (int i = 0; i < DEPTH; i++) begin
      expect_addr_rec(AW, sent_q[i], ts);
    end
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(32'(rdata[7:0]), 32'h0, "count after draining");
    apb_write(`AXI_TRACE_REG_STATUS, 32'h0);
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(32'(rdata[23:16]), 32'h0, "drop count after STATUS write");
  endtask

  task automatic apb_error_test();
    logic [31:0] ctrl_before;
    logic [31:0] rdata;
    apb_read(`AXI_TRACE_REG_CTRL, ctrl_before);
    apb_write(8'h20, 32'hFFFF_FFFF);
    check_eq(32'(apb_err), 32'h1, "pslverr on write to 0x20");
    apb_read(8'h20, rdata);
    check_eq(32'(apb_err), 32'h1, "pslverr on read from 0x20");
    apb_read(`AXI_TRACE_REG_CTRL, rdata);
    check_eq(rdata, ctrl_before, "CTRL after access to 0x20");
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(rdata, 32'h0, "STATUS after access to 0x20");
    apb_read(`AXI_TRACE_REG_W1, rdata);
    check_eq(rdata, 32'h0, "REC_W1 on an empty buffer");
    check_eq(32'(apb_err), 32'h0, "pslverr on REC_W1 read");
    apb_read(`AXI_TRACE_REG_STATUS, rdata);
    check_eq(32'(rdata[7:0]), 32'h0, "count after REC_W1 read on empty buffer");
  endtask

  initial begin
    void'($urandom(32'hb0b3));
    clk_i   = 1'b0;
    rst_ni  = 1'b1;
    axi_req = '0;
    axi_rsp = '0;
    apb_req = '0;
    apb_err = 1'b0;
    aw_stim = '0;
    ar_stim = '0;
    w_stim  = '0;
    b_stim  = '0;
    r_stim  = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b0;
    reset_state_test();
    addr_record_test();
    data_order_test();
    mask_filter_test();
    overflow_test();
    apb_error_test();
    repeat (2) @(posedge clk_i);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* axi_trace_top.f */
+incdir+.
axi_trace_pkg.sv
axi_beat_capture.sv
trace_serializer.sv
trace_fifo.sv
trace_apb_regs.sv
axi_trace_top.sv
axi_trace_properties.sv
tb_axi_trace.sv

/* run.sh */
#!/bin/sh
# Compile the AXI trace unit with its testbench and run it with Verilator.
# The run counts as passed only if the simulation log holds the pass line.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_trace \
  -f axi_trace_top.f -o tb_axi_trace > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_axi_trace > sim.log 2>&1
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
